// File: verilog/vmRouterPkg.sv
`default_nettype none

package vmRouterPkg;

    localparam int nLinks      = 3;
    localparam int stubWidth   = 36;
    localparam int vmStubWidth = 18;
    localparam int addrWidth   = 6;
    localparam int regionCount = 8;

    // read address, stub count and event index share this width
    typedef logic [addrWidth-1:0] linkAddrT;

    // barrel field layout, msb first
    typedef struct packed {
        logic [1:0] rHigh;
        logic [6:0] rLow;
        logic       zSide;
        logic [3:0] zVm;
        logic [4:0] zLow;
        logic [2:0] phiRegion;
        logic [1:0] phiVm;
        logic [8:0] phiLow;
        logic [2:0] pt;
    } barrelStubT;

    // disk layout keeps phi and pt in the same place as the barrel
    typedef struct packed {
        logic [1:0] rTop;
        logic       zSide;
        logic [3:0] rVm;
        logic [4:0] rLow;
        logic [1:0] zVm;
        logic [4:0] zLow;
        logic [2:0] phiRegion;
        logic [1:0] phiVm;
        logic [8:0] phiLow;
        logic [2:0] pt;
    } diskStubT;

    typedef union packed {
        barrelStubT barrel;
        diskStubT   disk;
    } stubWordT;

    typedef struct packed {
        stubWordT word;
        linkAddrT index;
    } linkStubT;

    typedef struct packed {
        logic [stubWidth-1:0]   fullStub;
        logic [vmStubWidth-1:0] vmStub;
        logic [regionCount-1:0] regionMask;
    } routedStubT;

endpackage

`default_nettype wire

// File: verilog/linkReader.sv
`timescale 1ns/1ps
`default_nettype none

module linkReader (
    input  wire                                                  clk,
    input  wire                                                  rstN,
    input  wire                                                  start,
    input  wire vmRouterPkg::linkAddrT [vmRouterPkg::nLinks-1:0] numberIn,
    input  wire vmRouterPkg::stubWordT [vmRouterPkg::nLinks-1:0] linkData,
    input  wire                                                  load,
    input  wire                                                  pipeEmpty,
    output logic [vmRouterPkg::nLinks-1:0]                       readEn,
    output vmRouterPkg::linkAddrT [vmRouterPkg::nLinks-1:0]      readAddr,
    output logic                                                 rdValid,
    output vmRouterPkg::linkStubT                                rdStub,
    output logic                                                 busy
);
    import vmRouterPkg::*;

    localparam int ptrWidth = $clog2(nLinks + 1);
    localparam logic [ptrWidth-1:0] noLink = ptrWidth'(nLinks);

    linkAddrT [nLinks-1:0] counts;
    logic [ptrWidth-1:0]   curLink;
    linkAddrT              curAddr;
    logic                  allIssued;
    logic                  issue;
    logic                  pop;
    logic                  readPending;
    logic [ptrWidth-1:0]   pendLink;
    linkStubT              bufMem [2];
    logic                  wrPtr;
    logic                  rdPtr;
    logic [1:0]            bufCount;
    logic [1:0]            occupancy;
    linkAddrT              eventIndex;

    // first link at or after fromLink that has stubs, noLink if none
    function automatic logic [ptrWidth-1:0] firstFrom(
        input logic [ptrWidth-1:0]   fromLink,
        input linkAddrT [nLinks-1:0] cnt
    );
        logic [ptrWidth-1:0] sel;
        sel = noLink;
        for (int i = nLinks - 1; i >= 0; i--) begin
            if (i >= fromLink && cnt[i] != '0) begin
                sel = ptrWidth'(i);
            end
        end
        return sel;
    endfunction

    ////////////////////////////////////////////////////////////
    // read issue

    assign allIssued = (curLink == noLink);
    assign pop       = rdValid && load;
    // a stub leaving this cycle frees its slot for a new read
    assign occupancy = bufCount + readPending - pop;
    assign issue     = busy && !allIssued && (occupancy < 2'd2);

    always_comb begin
        for (int i = 0; i < nLinks; i++) begin
            readEn[i]   = issue && (curLink == ptrWidth'(i));
            readAddr[i] = (curLink == ptrWidth'(i)) ? curAddr : '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            counts      <= '0;
            curLink     <= noLink;
            curAddr     <= '0;
            readPending <= 1'b0;
            pendLink    <= '0;
            busy        <= 1'b0;
        end else begin
            readPending <= issue;
            if (issue) begin
                pendLink <= curLink;
            end
            if (start) begin
                counts  <= numberIn;
                curLink <= firstFrom('0, numberIn);
                curAddr <= '0;
                busy    <= 1'b1;
            end else if (issue) begin
                if (curAddr == counts[curLink] - 1'b1) begin
                    curAddr <= '0;
                    curLink <= firstFrom(curLink + 1'b1, counts);
                end else begin
                    curAddr <= curAddr + 1'b1;
                end
            end else if (allIssued && !readPending && bufCount == '0 && pipeEmpty) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // two entry return buffer

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr      <= 1'b0;
            rdPtr      <= 1'b0;
            bufCount   <= '0;
            eventIndex <= '0;
        end else begin
            if (start) begin
                eventIndex <= '0;
            end else if (readPending) begin
                eventIndex <= eventIndex + 1'b1;
            end
            if (readPending) begin
                wrPtr <= !wrPtr;
            end
            if (pop) begin
                rdPtr <= !rdPtr;
            end
            bufCount <= bufCount + readPending - pop;
        end
    end

    // memory data is valid the cycle after its read
    always_ff @(posedge clk) begin
        if (readPending) begin
            bufMem[wrPtr] <= '{word: linkData[pendLink], index: eventIndex};
        end
    end

    assign rdValid = (bufCount != '0);
    assign rdStub  = bufMem[rdPtr];

endmodule

`default_nettype wire

// File: verilog/stubFormatter.sv
`timescale 1ns/1ps
`default_nettype none

module stubFormatter #(
    parameter bit isBarrel = 1'b1,
    parameter bit oddLayer = 1'b1
) (
    input  wire                                 clk,
    input  wire                                 rstN,
    input  wire                                 load,
    input  wire vmRouterPkg::linkStubT          rdStub,
    output logic [vmRouterPkg::stubWidth-1:0]   fullStub,
    output logic [vmRouterPkg::vmStubWidth-1:0] vmStub
);
    import vmRouterPkg::*;

    stubWordT               word;
    logic [stubWidth-1:0]   fullNext;
    logic [vmStubWidth-1:0] vmNext;

    assign word = rdStub.word;

    // pt sits in the low bits of both views and moves to the top
    assign fullNext = {word.barrel.pt, word.barrel[stubWidth-1:3]};

    always_comb begin
        if (isBarrel) begin
            vmNext = {word.barrel.pt, rdStub.index, word.barrel.zVm,
                      word.barrel.phiRegion[2] ^ oddLayer, word.barrel.phiVm,
                      word.barrel.rHigh};
        end else begin
            // disk phi modules are offset the other way
            vmNext = {word.disk.pt, rdStub.index, word.disk.zVm,
                      word.disk.phiRegion[2] ^ ~oddLayer, word.disk.phiVm,
                      word.disk.rVm};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fullStub <= '0;
            vmStub   <= '0;
        end else if (load) begin
            fullStub <= fullNext;
            vmStub   <= vmNext;
        end
    end

endmodule

`default_nettype wire

// File: verilog/regionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module regionDecoder #(
    parameter bit isBarrel = 1'b1,
    parameter bit oddLayer = 1'b1
) (
    input  wire                                 clk,
    input  wire                                 rstN,
    input  wire                                 load,
    input  wire vmRouterPkg::linkStubT          rdStub,
    output logic [vmRouterPkg::regionCount-1:0] regionMask
);
    import vmRouterPkg::*;

    // first phi region of group 0
    localparam logic [2:0] offset = isBarrel ? 3'(oddLayer) : 3'(!oddLayer);

    stubWordT               word;
    logic [2:0]             phiRegion;
    logic                   zSide;
    logic [2:0]             phiDelta;
    logic [1:0]             group;
    logic [regionCount-1:0] maskNext;

    assign word      = rdStub.word;
    // phi region sits at the same bits in both views
    assign phiRegion = word.barrel.phiRegion;
    assign zSide     = isBarrel ? word.barrel.zSide : word.disk.zSide;
    assign phiDelta  = phiRegion - offset;

    // two phi regions per group
    // a three bit delta halves to at most group 3
    assign group = phiDelta[2:1];

    always_comb begin
        if (word == '0 || phiRegion < offset) begin
            maskNext = '0;
        end else begin
            // lower four bits for z side 0, upper four for z side 1
            maskNext = regionCount'(1) << {zSide, group};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regionMask <= '0;
        end else if (load) begin
            regionMask <= maskNext;
        end
    end

endmodule

`default_nettype wire

// File: verilog/stubMerger.sv
`timescale 1ns/1ps
`default_nettype none

module stubMerger (
    input  wire                                 clk,
    input  wire                                 rstN,
    input  wire                                 rdValid,
    input  wire [vmRouterPkg::stubWidth-1:0]    fullStub,
    input  wire [vmRouterPkg::vmStubWidth-1:0]  vmStub,
    input  wire [vmRouterPkg::regionCount-1:0]  regionMask,
    input  wire                                 outReady,
    output logic                                load,
    output logic                                pipeEmpty,
    output logic                                outValid,
    output vmRouterPkg::routedStubT             outStub
);
    logic stageValid;
    logic outFree;
    logic move;

    // output register is free when empty or being accepted now
    assign outFree   = !outValid || outReady;
    assign move      = stageValid && outFree;
    assign load      = !stageValid || move;
    assign pipeEmpty = !stageValid && !outValid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stageValid <= 1'b0;
            outValid   <= 1'b0;
        end else begin
            if (rdValid && load) begin
                stageValid <= 1'b1;
            end else if (move) begin
                stageValid <= 1'b0;
            end
            if (move) begin
                outValid <= 1'b1;
            end else if (outReady) begin
                outValid <= 1'b0;
            end
        end
    end

    // held while stalled since move needs a free output
    always_ff @(posedge clk) begin
        if (move) begin
            outStub <= '{fullStub: fullStub, vmStub: vmStub, regionMask: regionMask};
        end
    end

endmodule

`default_nettype wire

// File: verilog/vmRouter.sv
`timescale 1ns/1ps
`default_nettype none

module vmRouter #(
    parameter bit isBarrel = 1'b1,
    parameter bit oddLayer = 1'b1
) (
    input  wire                                                  clk,
    input  wire                                                  rstN,
    input  wire                                                  start,
    input  wire vmRouterPkg::linkAddrT [vmRouterPkg::nLinks-1:0] numberIn,
    output logic [vmRouterPkg::nLinks-1:0]                       readEn,
    output vmRouterPkg::linkAddrT [vmRouterPkg::nLinks-1:0]      readAddr,
    input  wire vmRouterPkg::stubWordT [vmRouterPkg::nLinks-1:0] linkData,
    output logic                                                 outValid,
    input  wire                                                  outReady,
    output vmRouterPkg::routedStubT                              outStub,
    output logic                                                 busy
);
    import vmRouterPkg::*;

    logic                   rdValid;
    linkStubT               rdStub;
    logic                   load;
    logic                   pipeEmpty;
    logic [stubWidth-1:0]   fullStub;
    logic [vmStubWidth-1:0] vmStub;
    logic [regionCount-1:0] regionMask;

    ////////////////////////////////////////////////////////////
    // link reads

    linkReader reader (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .numberIn  (numberIn),
        .linkData  (linkData),
        .load      (load),
        .pipeEmpty (pipeEmpty),
        .readEn    (readEn),
        .readAddr  (readAddr),
        .rdValid   (rdValid),
        .rdStub    (rdStub),
        .busy      (busy)
    );

    ////////////////////////////////////////////////////////////
    // formatter and decoder see the same stub in parallel

    stubFormatter #(
        .isBarrel (isBarrel),
        .oddLayer (oddLayer)
    ) formatter (
        .clk      (clk),
        .rstN     (rstN),
        .load     (load),
        .rdStub   (rdStub),
        .fullStub (fullStub),
        .vmStub   (vmStub)
    );

    regionDecoder #(
        .isBarrel (isBarrel),
        .oddLayer (oddLayer)
    ) decoder (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .rdStub     (rdStub),
        .regionMask (regionMask)
    );

    stubMerger merger (
        .clk        (clk),
        .rstN       (rstN),
        .rdValid    (rdValid),
        .fullStub   (fullStub),
        .vmStub     (vmStub),
        .regionMask (regionMask),
        .outReady   (outReady),
        .load       (load),
        .pipeEmpty  (pipeEmpty),
        .outValid   (outValid),
        .outStub    (outStub)
    );

endmodule

`default_nettype wire

// File: tb/vmRouterChecker.sv
`timescale 1ns/1ps
`default_nettype none

module vmRouterChecker (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          outValid,
    input  wire                          outReady,
    input  wire vmRouterPkg::routedStubT outStub,
    input  wire                          busy,
    output int                           errorCount
);
    import vmRouterPkg::*;

    routedStubT expQ [$];
    routedStubT heldStub;
    logic       stalled;
    logic       busyLast;
    logic       inReset;
    int         eventStubs;
    int         eventErrors;
    int         totalStubs;
    int         eventCount;

    initial begin
        errorCount  = 0;
        eventStubs  = 0;
        eventErrors = 0;
        totalStubs  = 0;
        eventCount  = 0;
        stalled     = 1'b0;
        busyLast    = 1'b0;
        inReset     = 1'b0;
    end

    task automatic pushExpected(input routedStubT stub);
        expQ.push_back(stub);
    endtask

    task automatic countError();
        errorCount++;
        eventErrors++;
    endtask

    task automatic compareField(input string name, input logic [35:0] got,
                                input logic [35:0] want);
        if (got !== want) begin
            $display("FAILED %s in stub %0d: got %h expected %h",
                     name, eventStubs, got, want);
            countError();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // output handshake

    always @(posedge clk) begin
        routedStubT want;
        if (!rstN) begin
            stalled  <= 1'b0;
            busyLast <= 1'b0;
            inReset  <= 1'b1;
        end else begin
            // state left by reset, seen on the first edge after release
            if (inReset && (outValid !== 1'b0 || busy !== 1'b0)) begin
                $display("outValid or busy is not low after reset");
                countError();
            end
            inReset <= 1'b0;
            // a stalled stub must stay valid and unchanged
            if (stalled && outValid !== 1'b1) begin
                $display("outValid dropped while the output was stalled");
                countError();
            end else if (stalled && outStub !== heldStub) begin
                $display("FAILED outStub while stalled: got %h expected %h", outStub, heldStub);
                countError();
            end
            if (outValid && !busy) begin
                $display("outValid is high while busy is low");
                countError();
            end
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    $display("a stub was accepted when none was expected");
                    countError();
                end else begin
                    want = expQ.pop_front();
                    compareField("outStub.fullStub", 36'(outStub.fullStub), 36'(want.fullStub));
                    compareField("outStub.vmStub", 36'(outStub.vmStub), 36'(want.vmStub));
                    compareField("outStub.regionMask", 36'(outStub.regionMask),
                                 36'(want.regionMask));
                    eventStubs++;
                    totalStubs++;
                end
            end
            if (busyLast && !busy && expQ.size() != 0) begin
                $display("busy fell with %0d stubs still to come", expQ.size());
                countError();
            end
            stalled  <= outValid && !outReady;
            heldStub <= outStub;
            busyLast <= busy;
        end
    end

    task automatic finishEvent(input int ev);
        if (expQ.size() != 0) begin
            $display("event %0d ended with %0d expected stubs never seen", ev, expQ.size());
            countError();
            expQ.delete();
        end
        $display("event %0d done: %0d stubs checked, %0d errors", ev, eventStubs, eventErrors);
        eventStubs  = 0;
        eventErrors = 0;
        eventCount++;
    endtask

    task automatic printTotals();
        $display("%0d events, %0d stubs checked, %0d errors", eventCount, totalStubs, errorCount);
    endtask

endmodule

`default_nettype wire

// File: tb/vmRouterTb.sv
`timescale 1ns/1ps
`default_nettype none

module vmRouterTb;
    import vmRouterPkg::*;

    localparam int timeoutCycles = 2000;

    logic                  clk;
    logic                  rstN;
    logic                  start;
    linkAddrT [nLinks-1:0] numberIn;
    logic [nLinks-1:0]     readEn;
    linkAddrT [nLinks-1:0] readAddr;
    stubWordT [nLinks-1:0] linkData;
    logic                  outValid;
    logic                  outReady;
    routedStubT            outStub;
    logic                  busy;
    int                    errorCount;

    logic [63:0]           stimMem [0:255];
    stubWordT              linkMem [nLinks][64];
    logic [nLinks-1:0]     rdEnQ;
    linkAddrT [nLinks-1:0] rdAddrQ;
    int                    pos;
    int                    nEvents;
    int unsigned           seed;
    bit                    timedOut;

    vmRouter #(
        .isBarrel (1'b1),
        .oddLayer (1'b1)
    ) dut (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .numberIn (numberIn),
        .readEn   (readEn),
        .readAddr (readAddr),
        .linkData (linkData),
        .outValid (outValid),
        .outReady (outReady),
        .outStub  (outStub),
        .busy     (busy)
    );

    vmRouterChecker chk (
        .clk        (clk),
        .rstN       (rstN),
        .outValid   (outValid),
        .outReady   (outReady),
        .outStub    (outStub),
        .busy       (busy),
        .errorCount (errorCount)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // link memory models

    // capture the read on the rising edge, answer on the next falling edge
    always @(posedge clk) begin
        rdEnQ   <= readEn;
        rdAddrQ <= readAddr;
    end

    always @(negedge clk) begin
        for (int l = 0; l < nLinks; l++) begin
            if (rdEnQ[l]) begin
                linkData[l] <= linkMem[l][rdAddrQ[l]];
            end
        end
    end

    // random back-pressure, roughly five of eight cycles ready
    initial begin
        outReady = 1'b0;
        seed     = 32'hdf3f;
        void'($urandom(seed));
        forever begin
            @(negedge clk);
            outReady <= (($urandom % 8) < 5);
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    task automatic waitBusy(input logic level);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (busy !== level) begin
            $display("timeout while waiting for busy to become %0d", level);
            timedOut = 1'b1;
        end
    endtask

    task automatic runEvent();
        linkAddrT [nLinks-1:0] counts;
        int                    total;
        total = 0;
        for (int l = 0; l < nLinks; l++) begin
            counts[l] = stimMem[pos + l][addrWidth-1:0];
            total += counts[l];
        end
        pos += nLinks;
        for (int l = 0; l < nLinks; l++) begin
            for (int a = 0; a < counts[l]; a++) begin
                linkMem[l][a] = stimMem[pos][stubWidth-1:0];
                pos++;
            end
        end
        // expected outputs come in read order
        for (int s = 0; s < total; s++) begin
            chk.pushExpected({stimMem[pos][stubWidth-1:0],
                              stimMem[pos + 1][vmStubWidth-1:0],
                              stimMem[pos + 2][regionCount-1:0]});
            pos += 3;
        end
        @(negedge clk);
        numberIn = counts;
        start    = 1'b1;
        @(negedge clk);
        start    = 1'b0;
        waitBusy(1'b1);
        if (!timedOut) begin
            waitBusy(1'b0);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        start    = 1'b0;
        numberIn = '0;
        linkData = '0;
        rdEnQ    = '0;
        rdAddrQ  = '0;
        timedOut = 1'b0;
        for (int l = 0; l < nLinks; l++) begin
            for (int a = 0; a < 64; a++) begin
                linkMem[l][a] = 36'hbad000000 | 36'(l << 8) | 36'(a);
            end
        end
        $readmemh("tb/vmRouterStimulus.txt", stimMem);
        nEvents = int'(stimMem[0]);
        pos     = 1;

        repeat (10) @(negedge clk);
        rstN = 1'b1;
        repeat (2) @(negedge clk);

        for (int ev = 0; ev < nEvents && !timedOut; ev++) begin
            runEvent();
            // one more edge so the checker sees busy fall
            @(negedge clk);
            if (!timedOut) begin
                chk.finishEvent(ev);
            end
        end

        repeat (2) @(negedge clk);
        chk.printTotals();
        if (timedOut || errorCount != 0) begin
            $display("Finished with errors");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/vmRouterStimulus.txt
// event count, then per event: link 1 to 3 stub counts, then link 1, 2, 3 stub words
// then per stub in read order: fullStub vmStub regionMask
3
// event 0
2 1 2
AAAA66D2D 404C11002
C03C0B007
005418001 40200E004
B5554CDA5 2815A 01
480982200 10265 20
F80781600 385FF 01
200A83000 086A0 40
880401C00 20919 02
// event 1 skips links 1 and 3
// all zero word, phi region below offset, phi region 7
0 3 0
000000000 805801003 47E79D79E
000000000 00010 00
700B00200 182D6 00
C8FCF3AF3 30525 80
// event 2 skips link 2
3 0 2
803014000 00041F005 C05C06006
C03C0B007 AAAA66D2D
100602800 00182 04
A00083E00 2822C 08
D80B80C00 304FB 10
F80781600 387FF 01
B5554CDA5 2895A 01

// File: tb.f
verilog/vmRouterPkg.sv
verilog/linkReader.sv
verilog/stubFormatter.sv
verilog/regionDecoder.sv
verilog/stubMerger.sv
verilog/vmRouter.sv
tb/vmRouterChecker.sv
tb/vmRouterTb.sv
